// File: flist.f
+incdir+logic
logic/wb_pkg.sv
logic/wb_latch.sv
logic/regfile.sv
logic/hilo_unit.sv
logic/wb_top.sv
test/wb_props.sv
test/wb_checker.sv
test/tb_wb.sv

// File: Bender.yml
package:
  name: wb_writeback

sources:
  # design
  - include_dirs:
      - logic
    files:
      - logic/wb_pkg.sv
      - logic/wb_latch.sv
      - logic/regfile.sv
      - logic/hilo_unit.sv
      - logic/wb_top.sv
  # testbench
  - target: test
    include_dirs:
      - logic
    files:
      - test/wb_props.sv
      - test/wb_checker.sv
      - test/tb_wb.sv

// File: test/wb_input.txt
# flush, lane 1 (ctl wa wd srca hilo), lane 0 (ctl wa wd srca hilo), raddr x4, rdata x4, hi, lo
# ctl = {valid, regwrite, hiwrite, lowrite, op[1:0]}, every column in hex
0  00 0 0 0 0  00 0 0 0 0  1 2 3 0  0 0 0 0  0 0
0  30 1 11 0 0  00 0 0 0 0  1 2 3 0  0 0 0 0  0 0
0  00 0 0 0 0  30 2 22 0 0  1 2 0 0  11 0 0 0  0 0
0  00 0 0 0 0  00 0 0 0 0  1 2 3 0  11 22 0 0  0 0
0  30 3 aa 0 0  30 3 bb 0 0  1 2 3 3  11 22 0 0  0 0
0  30 0 dead 0 0  30 0 beef 0 0  3 3 3 3  bb bb bb bb  0 0
0  00 0 0 0 0  00 0 0 0 0  0 3 0 1  0 bb 0 11  0 0
1  30 1 ff 0 0  2d 0 0 77 0  1 2 3 0  11 22 bb 0  0 0
0  00 0 0 0 0  00 0 0 0 0  1 2 3 0  11 22 bb 0  0 0
0  00 0 0 0 0  00 0 0 0 0  1 2 3 0  11 22 bb 0  0 0
0  29 0 0 12 0  25 0 0 34 0  1 2 3 0  11 22 bb 0  0 0
0  3c 4 44 0 500000006  29 0 0 99 0  4 1 2 3  0 11 22 bb  0 0
0  00 0 0 0 0  00 0 0 0 0  4 0 0 0  44 0 0 0  12 34
0  00 0 0 0 0  00 0 0 0 0  4 1 2 3  44 11 22 bb  99 6
0  00 0 0 0 0  2c 0 0 0 1fffffffe  4 1 2 3  44 11 22 bb  99 6
0  2e 0 0 0 3  00 0 0 0 0  4 1 2 3  44 11 22 bb  99 6
0  2f 0 0 0 10  2e 0 0 0 200000000  4 1 2 3  44 11 22 bb  1 fffffffe
0  00 0 0 0 0  00 0 0 0 0  4 1 2 3  44 11 22 bb  2 1
0  2f 0 0 0 5  00 0 0 0 0  4 1 2 3  44 11 22 bb  4 1
0  00 0 0 0 0  2f 0 0 0 3fffffffd  4 1 2 3  44 11 22 bb  4 1
0  00 0 0 0 0  00 0 0 0 0  4 1 2 3  44 11 22 bb  3 fffffffc
0  00 0 0 0 0  00 0 0 0 0  4 1 2 3  44 11 22 bb  ffffffff ffffffff

// File: test/tb_wb.sv
`include "wb_macros.svh"

module tb_wb
    import wb_pkg::*;
();

    localparam int MAX_CYCLES = 100;
    localparam int NUM_FIELDS = 21;

    logic                             clk;
    logic                             reset;
    logic                             flush;
    wb_lane_t  [`WB_NUM_LANES-1:0]    lanes;
    reg_addr_t [`WB_NUM_RPORTS-1:0]   raddr;
    word_t     [`WB_NUM_RPORTS-1:0]   rdata;
    word_t                            hi;
    word_t                            lo;

    // expected values for the cycle being driven
    logic                             check_en;
    word_t     [`WB_NUM_RPORTS-1:0]   exp_rdata;
    word_t                            exp_hi;
    word_t                            exp_lo;

    int value_errs;
    int assert_errs;
    int file_errs;
    int timeouts;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    wb_top dut (
        .clk     (clk),
        .reset   (reset),
        .i_flush (flush),
        .i_lanes (lanes),
        .i_raddr (raddr),
        .o_rdata (rdata),
        .o_hi    (hi),
        .o_lo    (lo)
    );

    wb_checker u_checker (
        .clk         (clk),
        .i_check     (check_en),
        .i_exp_rdata (exp_rdata),
        .i_exp_hi    (exp_hi),
        .i_exp_lo    (exp_lo),
        .i_rdata     (rdata),
        .i_hi        (hi),
        .i_lo        (lo),
        .o_err_count (value_errs)
    );

    bind wb_top wb_props u_wb_props (
        .clk     (clk),
        .reset   (reset),
        .i_lanes (lanes_w),
        .i_raddr (i_raddr),
        .i_rdata (o_rdata),
        .i_hi    (o_hi),
        .i_lo    (o_lo)
    );

    // ctl holds valid, regwrite, hiwrite, lowrite and the 2-bit op
    function automatic wb_lane_t lane_from_fields(
        input logic [63:0] ctl,
        input logic [63:0] wa,
        input logic [63:0] wd,
        input logic [63:0] srca,
        input logic [63:0] hilo
    );
        wb_lane_t lane;
        lane          = '0;
        lane.valid    = ctl[5];
        lane.regwrite = ctl[4];
        lane.hiwrite  = ctl[3];
        lane.lowrite  = ctl[2];
        lane.hilo_op  = hilo_op_e'(ctl[1:0]);
        lane.wa       = wa[`WB_REG_AW-1:0];
        lane.wd       = wd[`WB_WORD_W-1:0];
        lane.srca     = srca[`WB_WORD_W-1:0];
        lane.hilo     = hilo[`WB_HILO_W-1:0];
        return lane;
    endfunction

    // skips comment and blank lines
    task automatic read_data_line(input int fd, output string line, output bit found);
        int r;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            r = $fgets(line, fd);
            if ((r > 0) && (line.len() > 1) && (line[0] != "#")) begin
                found = 1'b1;
            end
        end
    endtask

    initial begin
        int          fd;
        string       line;
        bit          found;
        bit          done;
        int          n;
        int          cycles;
        int          line_no;
        logic [63:0] f [NUM_FIELDS];
        reset     = 1'b1;
        flush     = 1'b0;
        lanes     = '0;
        raddr     = '0;
        check_en  = 1'b0;
        exp_rdata = '0;
        exp_hi    = '0;
        exp_lo    = '0;
        file_errs = 0;
        timeouts  = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        fd = $fopen("test/wb_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the data file test/wb_input.txt");
            file_errs++;
        end else begin
            done    = 1'b0;
            cycles  = 0;
            line_no = 0;
            while (!done && (cycles < MAX_CYCLES)) begin
                read_data_line(fd, line, found);
                if (!found) begin
                    done     = 1'b1;
                    check_en = 1'b0;
                end else begin
                    line_no++;
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
                    if (n != NUM_FIELDS) begin
                        $display("data line %0d is short: %0d of %0d fields", line_no, n,
                            NUM_FIELDS);
                        file_errs++;
                        flush    = 1'b0;
                        lanes    = '0;
                        check_en = 1'b0;
                    end else begin
                        flush    = f[0][0];
                        lanes[1] = lane_from_fields(f[1], f[2], f[3], f[4], f[5]);
                        lanes[0] = lane_from_fields(f[6], f[7], f[8], f[9], f[10]);
                        for (int p = 0; p < `WB_NUM_RPORTS; p++) begin
                            raddr[p]     = f[11+p][`WB_REG_AW-1:0];
                            exp_rdata[p] = f[15+p][`WB_WORD_W-1:0];
                        end
                        exp_hi   = f[19][`WB_WORD_W-1:0];
                        exp_lo   = f[20][`WB_WORD_W-1:0];
                        check_en = 1'b1;
                    end
                    @(negedge clk);
                    cycles++;
                end
            end
            if (!done) begin
                $display("timeout: the data file did not end within %0d cycles", MAX_CYCLES);
                timeouts++;
            end
            $fclose(fd);
        end
        assert_errs = dut.u_wb_props.r0_fails + dut.u_wb_props.hold_fails
                    + dut.u_wb_props.reset_fails;
        $display("errors: %0d value, %0d assertion, %0d data file, %0d timeout",
            value_errs, assert_errs, file_errs, timeouts);
        if ((value_errs + assert_errs + file_errs + timeouts) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: test/wb_checker.sv
`include "wb_macros.svh"

module wb_checker
    import wb_pkg::*;
(
    input  logic                            clk,
    input  logic                            i_check,
    input  word_t [`WB_NUM_RPORTS-1:0]      i_exp_rdata,
    input  word_t                           i_exp_hi,
    input  word_t                           i_exp_lo,
    input  word_t [`WB_NUM_RPORTS-1:0]      i_rdata,
    input  word_t                           i_hi,
    input  word_t                           i_lo,
    output int                              o_err_count
);

    int errors = 0;
    int checks = 0;

    // one word against its expected value, unknown bits count as wrong
    task automatic compare_word(
        input string name,
        input word_t expected,
        input word_t actual
    );
        if (actual !== expected) begin
            $display("ERR %s check %0d: expected %h got %h", name, checks, expected, actual);
            errors++;
        end
    endtask

    // outputs are sampled just before the edge, where they have settled
    always @(posedge clk) begin
        if (i_check) begin
            checks++;
            for (int p = 0; p < `WB_NUM_RPORTS; p++) begin
                compare_word($sformatf("o_rdata[%0d]", p), i_exp_rdata[p], i_rdata[p]);
            end
            compare_word("o_hi", i_exp_hi, i_hi);
            compare_word("o_lo", i_exp_lo, i_lo);
        end
    end

    assign o_err_count = errors;

endmodule

// File: test/wb_props.sv
`include "wb_macros.svh"

module wb_props
    import wb_pkg::*;
(
    input logic                             clk,
    input logic                             reset,
    input wb_lane_t  [`WB_NUM_LANES-1:0]    i_lanes,
    input reg_addr_t [`WB_NUM_RPORTS-1:0]   i_raddr,
    input word_t     [`WB_NUM_RPORTS-1:0]   i_rdata,
    input word_t                            i_hi,
    input word_t                            i_lo
);

    int r0_fails = 0;
    int hold_fails = 0;
    int reset_fails = 0;

    logic r0_ok;
    logic hilo_touched;

    always_comb begin
        r0_ok        = 1'b1;
        hilo_touched = 1'b0;
        for (int p = 0; p < `WB_NUM_RPORTS; p++) begin
            if ((i_raddr[p] == '0) && (i_rdata[p] != '0)) begin
                r0_ok = 1'b0;
            end
        end
        // any latched lane that will update HI or LO at this edge
        for (int l = 0; l < `WB_NUM_LANES; l++) begin
            if (i_lanes[l].valid && (i_lanes[l].hiwrite || i_lanes[l].lowrite)) begin
                hilo_touched = 1'b1;
            end
        end
    end

    r0_reads_zero: assert property (@(posedge clk) disable iff (reset) r0_ok)
        else begin
            $error("a read port returned nonzero data for r0");
            r0_fails++;
        end

    hilo_holds: assert property (@(posedge clk) disable iff (reset)
        !hilo_touched |=> ($stable(i_hi) && $stable(i_lo)))
        else begin
            $error("HI or LO changed without a latched HI/LO write");
            hold_fails++;
        end

    hilo_reset: assert property (@(posedge clk) reset |=> ((i_hi == '0) && (i_lo == '0)))
        else begin
            $error("HI or LO not cleared after reset");
            reset_fails++;
        end

endmodule

// File: logic/wb_top.sv
`include "wb_macros.svh"

module wb_top
    import wb_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                i_flush,
    input  wb_lane_t  [`WB_NUM_LANES-1:0]       i_lanes,
    input  reg_addr_t [`WB_NUM_RPORTS-1:0]      i_raddr,
    output word_t     [`WB_NUM_RPORTS-1:0]      o_rdata,
    output word_t                               o_hi,
    output word_t                               o_lo
);

    // latched lanes and their qualified register writes
    wb_lane_t  [`WB_NUM_LANES-1:0] lanes_w;
    rf_write_t [`WB_NUM_LANES-1:0] rf_wr;

    wb_latch u_wb_latch (
        .clk     (clk),
        .reset   (reset),
        .i_flush (i_flush),
        .i_lanes (i_lanes),
        .o_lanes (lanes_w),
        .o_rf_wr (rf_wr)
    );

    regfile #(
        .NUM_RPORTS (`WB_NUM_RPORTS)
    ) u_regfile (
        .clk     (clk),
        .reset   (reset),
        .i_wr    (rf_wr),
        .i_raddr (i_raddr),
        .o_rdata (o_rdata)
    );

    // HI/LO sees the full lanes, not just the register writes
    hilo_unit u_hilo_unit (
        .clk     (clk),
        .reset   (reset),
        .i_lanes (lanes_w),
        .o_hi    (o_hi),
        .o_lo    (o_lo)
    );

endmodule

// File: logic/hilo_unit.sv
`include "wb_macros.svh"

module hilo_unit
    import wb_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  wb_lane_t [`WB_NUM_LANES-1:0]    i_lanes,
    output word_t                           o_hi,
    output word_t                           o_lo
);

    word_t hi_q;
    word_t lo_q;

    logic  hi_we;
    logic  lo_we;
    word_t hi_nxt;
    word_t lo_nxt;

    // full 64-bit candidate for one lane, both halves at once
    // accumulate always starts from the value held before the edge
    function automatic logic [`WB_HILO_W-1:0] lane_result(
        input wb_lane_t              lane,
        input logic [`WB_HILO_W-1:0] old
    );
        logic [`WB_HILO_W-1:0] res;
        case (lane.hilo_op)
            HILO_MOVE: res = {lane.srca, lane.srca};
            HILO_PROD: res = lane.hilo;
            HILO_ADD:  res = old + lane.hilo;
            HILO_SUB:  res = old - lane.hilo;
            default:   res = lane.hilo;
        endcase
        return res;
    endfunction

    // walk from the older lane to the younger so lane 0 overrides
    always_comb begin
        logic [`WB_HILO_W-1:0] old_hilo;
        logic [`WB_HILO_W-1:0] res;
        old_hilo = {hi_q, lo_q};
        hi_we    = 1'b0;
        lo_we    = 1'b0;
        hi_nxt   = hi_q;
        lo_nxt   = lo_q;
        for (int l = `WB_NUM_LANES - 1; l >= 0; l--) begin
            res = lane_result(i_lanes[l], old_hilo);
            if (i_lanes[l].valid && i_lanes[l].hiwrite) begin
                hi_we  = 1'b1;
                hi_nxt = res[`WB_HILO_W-1:`WB_WORD_W];
            end
            if (i_lanes[l].valid && i_lanes[l].lowrite) begin
                lo_we  = 1'b1;
                lo_nxt = res[`WB_WORD_W-1:0];
            end
        end
    end

    // separate enables, an untouched half holds
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            if (hi_we) begin
                hi_q <= hi_nxt;
            end
            if (lo_we) begin
                lo_q <= lo_nxt;
            end
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

endmodule

// File: logic/regfile.sv
`include "wb_macros.svh"

module regfile
    import wb_pkg::*;
#(
    parameter int NUM_RPORTS = `WB_NUM_RPORTS
) (
    input  logic                                clk,
    input  logic                                reset,
    input  rf_write_t [`WB_NUM_LANES-1:0]       i_wr,
    input  reg_addr_t [NUM_RPORTS-1:0]          i_raddr,
    output word_t     [NUM_RPORTS-1:0]          o_rdata
);

    // r0 has no storage
    word_t regs [1:`WB_NUM_REGS-1];

    // lane 1 first, lane 0 last so the younger write lands
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 1; r < `WB_NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = `WB_NUM_LANES - 1; l >= 0; l--) begin
                if (i_wr[l].we) begin
                    regs[i_wr[l].wa] <= i_wr[l].wd;
                end
            end
        end
    end

    // read ports with write-through of the lanes retiring this cycle
    always_comb begin
        for (int p = 0; p < NUM_RPORTS; p++) begin
            if (i_raddr[p] == '0) begin
                o_rdata[p] = '0;
            end else if (i_wr[0].we && (i_wr[0].wa == i_raddr[p])) begin
                // younger lane has priority
                o_rdata[p] = i_wr[0].wd;
            end else if (i_wr[1].we && (i_wr[1].wa == i_raddr[p])) begin
                o_rdata[p] = i_wr[1].wd;
            end else begin
                o_rdata[p] = regs[i_raddr[p]];
            end
        end
    end

endmodule

// File: logic/wb_latch.sv
`include "wb_macros.svh"

module wb_latch
    import wb_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 i_flush,
    input  wb_lane_t  [`WB_NUM_LANES-1:0]        i_lanes,
    output wb_lane_t  [`WB_NUM_LANES-1:0]        o_lanes,
    output rf_write_t [`WB_NUM_LANES-1:0]        o_rf_wr
);

    wb_lane_t [`WB_NUM_LANES-1:0] lanes_q;

    // memory-to-writeback register, never stalls
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            lanes_q <= '0;
        end else begin
            lanes_q <= i_lanes;
        end
    end

    assign o_lanes = lanes_q;

    // qualified register writes
    // a write to r0 is dropped here so the register file never looks at it
    always_comb begin
        for (int l = 0; l < `WB_NUM_LANES; l++) begin
            o_rf_wr[l].we = lanes_q[l].valid
                         && lanes_q[l].regwrite
                         && (lanes_q[l].wa != '0);
            o_rf_wr[l].wa = lanes_q[l].wa;
            o_rf_wr[l].wd = lanes_q[l].wd;
        end
    end

endmodule

// File: logic/wb_pkg.sv
`include "wb_macros.svh"

package wb_pkg;

    // one data word
    typedef logic [`WB_WORD_W-1:0] word_t;

    // general register number
    typedef logic [`WB_REG_AW-1:0] reg_addr_t;

    // how a lane updates HI and LO
    typedef enum logic [1:0] {
        // matching half of the product
        HILO_PROD = 2'd0,
        // source word, for MTHI / MTLO
        HILO_MOVE = 2'd1,
        // HI:LO plus the 64-bit value
        HILO_ADD  = 2'd2,
        // HI:LO minus the 64-bit value
        HILO_SUB  = 2'd3
    } hilo_op_e;

    // one retiring instruction as it leaves the memory stage
    typedef struct packed {
        logic                   valid;
        logic                   regwrite;
        // destination register and its result
        reg_addr_t              wa;
        word_t                  wd;
        // HI / LO side
        logic                   hiwrite;
        logic                   lowrite;
        hilo_op_e               hilo_op;
        word_t                  srca;
        logic [`WB_HILO_W-1:0]  hilo;
    } wb_lane_t;

    // one qualified register write, we already covers valid and r0
    typedef struct packed {
        logic      we;
        reg_addr_t wa;
        word_t     wd;
    } rf_write_t;

endpackage

// File: logic/wb_macros.svh
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// data word width
`define WB_WORD_W 32

// general register address width
`define WB_REG_AW 5

// number of general registers, r0 included
`define WB_NUM_REGS 32

// issue lanes, lane 1 older
`define WB_NUM_LANES 2

// register file read ports
`define WB_NUM_RPORTS 4

// multiplier product and HI:LO width
`define WB_HILO_W 64

`endif
